// ==== fpm_cfg.svh ====
`ifndef FPM_CFG_SVH
`define FPM_CFG_SVH

// ---------------------------------------------------------------------------
// Coprocessor sizing
// ---------------------------------------------------------------------------

`define FPM_NUM_F_REGS   32  // FP register file depth
`define FPM_FLEN         32  // Single precision only
`define FPM_XLEN         32  // Host integer width

// Id width of the eXtension interface
`define FPM_ID_WIDTH     4

// Speculative queue entries, also the issue credit count
`define FPM_QUEUE_DEPTH  4

`endif

// ==== fpm_pkg.sv ====
`include "fpm_cfg.svh"

package fpm_pkg;

  // -------------------------------------------------------------------------
  // Data widths
  // -------------------------------------------------------------------------

  typedef logic [`FPM_FLEN-1:0]     fp_word_t;  // One FP register
  typedef logic [`FPM_XLEN-1:0]     x_word_t;   // Integer operand, result, address
  typedef logic [31:0]              instr_t;    // Raw instruction word
  typedef logic [`FPM_ID_WIDTH-1:0] xid_t;      // Host instruction id

  // Register index, 5 bits for 32 registers
  typedef logic [$clog2(`FPM_NUM_F_REGS)-1:0] reg_idx_t;

  // -------------------------------------------------------------------------
  // Encodings
  // -------------------------------------------------------------------------

  // Decoded operation, the only thing the queue and execute see
  typedef enum logic [2:0] {
    OP_FSGNJ   = 3'd0,  // Sign from rs2
    OP_FSGNJN  = 3'd1,  // Inverted rs2 sign
    OP_FSGNJX  = 3'd2,  // XOR of both signs
    OP_FMV_W_X = 3'd3,  // Integer into FP reg
    OP_FMV_X_W = 3'd4,  // FP reg back to the host
    OP_FLW     = 3'd5,
    OP_FSW     = 3'd6
  } op_kind_t;

  // Execute FSM
  typedef enum logic [1:0] {
    EXE_IDLE     = 2'd0,  // Ready for an op
    EXE_MEM_REQ  = 2'd1,  // Request out, waiting for mem_ready
    EXE_MEM_WAIT = 2'd2,  // Load in flight
    EXE_RESULT   = 2'd3   // Result out, waiting for result_ready
  } exe_state_t;

endpackage

// ==== fpm_op_if.sv ====
`timescale 1ns/1ps

// One decoded operation moving downstream, one credit moving back
interface fpm_op_if import fpm_pkg::*; ();

  logic     op_valid;  // Spends one credit
  op_kind_t kind;
  xid_t     id;
  reg_idx_t rd;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  x_word_t  xval;      // Integer rs1 or effective address
  logic     credit;    // Pulse per freed sink slot

  // Upstream side
  modport source (
    output op_valid,
    output kind,
    output id,
    output rd,
    output rs1_idx,
    output rs2_idx,
    output xval,
    input  credit
  );

  // Downstream side
  modport sink (
    input  op_valid,
    input  kind,
    input  id,
    input  rd,
    input  rs1_idx,
    input  rs2_idx,
    input  xval,
    output credit
  );

endinterface

// ==== fpm_issue.sv ====
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fpm_issue import fpm_pkg::*; (
  input  logic    ck,
  input  logic    rst,
  input  logic    issue_valid,
  output logic    issue_ready,
  input  instr_t  issue_instr,
  input  xid_t    issue_id,
  input  x_word_t issue_rs1,
  output logic    issue_accept,
  output logic    issue_writeback,
  fpm_op_if.source q
);

  localparam int CW = $clog2(`FPM_QUEUE_DEPTH + 1);

  localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

  logic [CW-1:0] cred_q;   // Free queue slots
  logic          take;
  op_kind_t      dec_kind;
  x_word_t       imm_i, imm_s;

  // ---------------------------------------------------------------------------
  // Predecode
  // ---------------------------------------------------------------------------

  always_comb begin
    issue_accept = 1'b0;
    dec_kind     = OP_FSGNJ;
    case (issue_instr[6:0])
      OPC_OP_FP: begin
        if (issue_instr[31:25] == 7'b0010000) begin  // FSGNJ group, rm picks the rule
          issue_accept = (issue_instr[14:12] <= 3'b010);
          if (issue_instr[14:12] == 3'b001) dec_kind = OP_FSGNJN;
          else if (issue_instr[14:12] == 3'b010) dec_kind = OP_FSGNJX;
        end else if (issue_instr[14:12] == 3'b000 && issue_instr[24:20] == 5'd0) begin
          // Moves need rm and rs2 zero
          if (issue_instr[31:25] == 7'b1110000) begin
            issue_accept = 1'b1;
            dec_kind     = OP_FMV_X_W;
          end else if (issue_instr[31:25] == 7'b1111000) begin
            issue_accept = 1'b1;
            dec_kind     = OP_FMV_W_X;
          end
        end
      end
      OPC_LOAD_FP: begin
        issue_accept = (issue_instr[14:12] == 3'b010);  // Word width only
        dec_kind     = OP_FLW;
      end
      OPC_STORE_FP: begin
        issue_accept = (issue_instr[14:12] == 3'b010);
        dec_kind     = OP_FSW;
      end
      default: ;
    endcase
  end

  assign issue_writeback = issue_accept && (dec_kind == OP_FMV_X_W);  // Only move to X

  // Address offsets, sign extended
  assign imm_i = {{(`FPM_XLEN-12){issue_instr[31]}}, issue_instr[31:20]};
  assign imm_s = {{(`FPM_XLEN-12){issue_instr[31]}}, issue_instr[31:25], issue_instr[11:7]};

  assign issue_ready = (cred_q != '0);
  assign take        = issue_valid && issue_ready && issue_accept;

  // ---------------------------------------------------------------------------
  // Credits and push
  // ---------------------------------------------------------------------------

  always_ff @(posedge ck or negedge rst) begin
    if (!rst) begin
      cred_q     <= CW'(`FPM_QUEUE_DEPTH);  // Queue starts empty
      q.op_valid <= 1'b0;
    end else begin
      q.op_valid <= take;  // Entry lands in queue next cycle
      case ({take, q.credit})
        2'b10:   cred_q <= cred_q - 1'b1;
        2'b01:   cred_q <= cred_q + 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge ck) begin
    if (take) begin
      q.kind    <= dec_kind;
      q.id      <= issue_id;
      q.rd      <= issue_instr[11:7];
      q.rs1_idx <= issue_instr[19:15];
      q.rs2_idx <= issue_instr[24:20];
      case (dec_kind)
        OP_FLW:  q.xval <= issue_rs1 + imm_i;
        OP_FSW:  q.xval <= issue_rs1 + imm_s;
        default: q.xval <= issue_rs1;  // FMV.W.X source
      endcase
    end
  end

endmodule

// ==== fpm_op_queue.sv ====
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fpm_op_queue import fpm_pkg::*; (
  input  logic ck,
  input  logic rst,
  input  logic commit_valid,
  input  xid_t commit_id,
  input  logic commit_kill,
  fpm_op_if.sink   q,
  fpm_op_if.source x
);

  localparam int DEPTH = `FPM_QUEUE_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Entry payload
  op_kind_t kind_m [DEPTH];
  xid_t     id_m   [DEPTH];
  reg_idx_t rd_m   [DEPTH];
  reg_idx_t rs1_m  [DEPTH];
  reg_idx_t rs2_m  [DEPTH];
  x_word_t  xval_m [DEPTH];

  logic [DEPTH-1:0] occ_q;   // Slot holds an op
  logic [DEPTH-1:0] dec_q;   // Commit or kill seen
  logic [DEPTH-1:0] kill_q;  // Decision was kill
  logic [PW-1:0]    head_q, tail_q;
  logic             x_cred_q;  // Execute has a free slot
  logic             head_dec, drop, send, pop;
  logic             push_hit;

  function automatic logic [PW-1:0] ptr_inc(logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // ---------------------------------------------------------------------------
  // Head decision
  // ---------------------------------------------------------------------------

  assign head_dec = occ_q[head_q] && dec_q[head_q];  // Undecided head blocks
  assign drop     = head_dec && kill_q[head_q];
  assign send     = head_dec && !kill_q[head_q] && x_cred_q;
  assign pop      = drop || send;

  // Commit arriving with the push of its own op
  assign push_hit = commit_valid && q.op_valid && (commit_id == q.id);

  always_ff @(posedge ck or negedge rst) begin
    if (!rst) begin
      occ_q      <= '0;
      dec_q      <= '0;
      kill_q     <= '0;
      head_q     <= '0;
      tail_q     <= '0;
      x_cred_q   <= 1'b1;  // Execute starts idle
      q.credit   <= 1'b0;
      x.op_valid <= 1'b0;
    end else begin
      q.credit   <= pop;   // Slot back to issue a cycle later
      x.op_valid <= send;
      x_cred_q   <= (x_cred_q && !send) || x.credit;

      // Mark pending entries by id
      if (commit_valid) begin
        for (int i = 0; i < DEPTH; i++) begin
          if (occ_q[i] && !dec_q[i] && id_m[i] == commit_id) begin
            dec_q[i]  <= 1'b1;
            kill_q[i] <= commit_kill;
          end
        end
      end

      if (pop) begin
        occ_q[head_q] <= 1'b0;
        head_q        <= ptr_inc(head_q);
      end

      if (q.op_valid) begin  // Credit guarantees a free tail
        occ_q[tail_q]  <= 1'b1;
        dec_q[tail_q]  <= push_hit;
        kill_q[tail_q] <= push_hit && commit_kill;
        tail_q         <= ptr_inc(tail_q);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Payload storage and execute port
  // ---------------------------------------------------------------------------

  always_ff @(posedge ck) begin
    if (q.op_valid) begin
      kind_m[tail_q] <= q.kind;
      id_m[tail_q]   <= q.id;
      rd_m[tail_q]   <= q.rd;
      rs1_m[tail_q]  <= q.rs1_idx;
      rs2_m[tail_q]  <= q.rs2_idx;
      xval_m[tail_q] <= q.xval;
    end
    if (send) begin  // Committed head goes out
      x.kind    <= kind_m[head_q];
      x.id      <= id_m[head_q];
      x.rd      <= rd_m[head_q];
      x.rs1_idx <= rs1_m[head_q];
      x.rs2_idx <= rs2_m[head_q];
      x.xval    <= xval_m[head_q];
    end
  end

endmodule

// ==== fpm_execute.sv ====
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fpm_execute import fpm_pkg::*; (
  input  logic     ck,
  input  logic     rst,
  fpm_op_if.sink   x,
  output logic     mem_valid,
  input  logic     mem_ready,
  output logic     mem_we,
  output x_word_t  mem_addr,
  output fp_word_t mem_wdata,
  output xid_t     mem_id,
  input  logic     mem_result_valid,
  input  fp_word_t mem_rdata,
  output logic     result_valid,
  input  logic     result_ready,
  output xid_t     result_id,
  output reg_idx_t result_rd,
  output x_word_t  result_data
);

  localparam int SB = `FPM_FLEN - 1;  // Sign bit

  fp_word_t   rf [`FPM_NUM_F_REGS];
  exe_state_t state_q, nxt_state;
  logic       done;      // Op finished this cycle
  logic       rf_we;
  reg_idx_t   rf_waddr;
  fp_word_t   rf_wdata;
  fp_word_t   sgnj_res;
  logic       take;

  // Payload of the op in flight
  xid_t     id_q;
  reg_idx_t rd_q;
  x_word_t  addr_q;
  logic     we_q;
  fp_word_t wdata_q;
  x_word_t  res_q;

  // Magnitude of a, sign by rule
  function automatic fp_word_t sgnj(op_kind_t k, fp_word_t a, fp_word_t b);
    logic s;
    case (k)
      OP_FSGNJN: s = ~b[SB];
      OP_FSGNJX: s = a[SB] ^ b[SB];
      default:   s = b[SB];
    endcase
    return {s, a[SB-1:0]};
  endfunction

  assign sgnj_res = sgnj(x.kind, rf[x.rs1_idx], rf[x.rs2_idx]);
  assign take     = (state_q == EXE_IDLE) && x.op_valid;

  // ---------------------------------------------------------------------------
  // Sequencing
  // ---------------------------------------------------------------------------

  always_comb begin
    nxt_state = state_q;
    done      = 1'b0;
    rf_we     = 1'b0;
    rf_waddr  = x.rd;
    rf_wdata  = sgnj_res;
    case (state_q)
      EXE_IDLE: begin
        if (x.op_valid) begin
          case (x.kind)
            OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: begin
              rf_we = 1'b1;  // Single cycle
              done  = 1'b1;
            end
            OP_FMV_W_X: begin
              rf_we    = 1'b1;
              rf_wdata = x.xval;  // Raw bits, no conversion
              done     = 1'b1;
            end
            OP_FMV_X_W: nxt_state = EXE_RESULT;
            default:    nxt_state = EXE_MEM_REQ;  // FLW and FSW
          endcase
        end
      end
      EXE_MEM_REQ: begin
        if (mem_ready) begin
          if (we_q) begin  // Store done at handshake
            done      = 1'b1;
            nxt_state = EXE_IDLE;
          end else if (mem_result_valid) begin  // Zero latency load
            rf_we     = 1'b1;
            rf_waddr  = rd_q;
            rf_wdata  = mem_rdata;
            done      = 1'b1;
            nxt_state = EXE_IDLE;
          end else begin
            nxt_state = EXE_MEM_WAIT;
          end
        end
      end
      EXE_MEM_WAIT: begin
        if (mem_result_valid) begin
          rf_we     = 1'b1;
          rf_waddr  = rd_q;
          rf_wdata  = mem_rdata;
          done      = 1'b1;
          nxt_state = EXE_IDLE;
        end
      end
      EXE_RESULT: begin
        if (result_ready) begin
          done      = 1'b1;
          nxt_state = EXE_IDLE;
        end
      end
      default: nxt_state = EXE_IDLE;
    endcase
  end

  assign x.credit = done;  // Slot free again

  always_ff @(posedge ck or negedge rst) begin
    if (!rst) begin
      state_q <= EXE_IDLE;
      for (int i = 0; i < `FPM_NUM_F_REGS; i++) begin
        rf[i] <= '0;
      end
    end else begin
      state_q <= nxt_state;
      if (rf_we) rf[rf_waddr] <= rf_wdata;
    end
  end

  // Operands captured when the op is taken
  always_ff @(posedge ck) begin
    if (take) begin
      id_q    <= x.id;
      rd_q    <= x.rd;
      addr_q  <= x.xval;
      we_q    <= (x.kind == OP_FSW);
      wdata_q <= rf[x.rs2_idx];  // Store data
      res_q   <= rf[x.rs1_idx];  // FMV.X.W source
    end
  end

  // ---------------------------------------------------------------------------
  // Host channels
  // ---------------------------------------------------------------------------

  assign mem_valid    = (state_q == EXE_MEM_REQ);
  assign mem_we       = we_q;
  assign mem_addr     = addr_q;
  assign mem_wdata    = wdata_q;
  assign mem_id       = id_q;

  assign result_valid = (state_q == EXE_RESULT);
  assign result_id    = id_q;
  assign result_rd    = rd_q;   // Integer destination
  assign result_data  = res_q;

endmodule

// ==== fpm_top.sv ====
`timescale 1ns/1ps

module fpm_top import fpm_pkg::*; (
  input  logic     ck,
  input  logic     rst,
  // Issue
  input  logic     issue_valid,
  output logic     issue_ready,
  input  instr_t   issue_instr,
  input  xid_t     issue_id,
  input  x_word_t  issue_rs1,
  output logic     issue_accept,
  output logic     issue_writeback,
  // Commit
  input  logic     commit_valid,
  input  xid_t     commit_id,
  input  logic     commit_kill,
  // Memory request and result
  output logic     mem_valid,
  input  logic     mem_ready,
  output logic     mem_we,
  output x_word_t  mem_addr,
  output fp_word_t mem_wdata,
  output xid_t     mem_id,
  input  logic     mem_result_valid,
  input  fp_word_t mem_rdata,
  // Result
  output logic     result_valid,
  input  logic     result_ready,
  output xid_t     result_id,
  output reg_idx_t result_rd,
  output x_word_t  result_data
);

  fpm_op_if link_q ();  // Issue to queue
  fpm_op_if link_x ();  // Queue to execute

  fpm_issue u_issue (
    .ck, .rst,
    .issue_valid, .issue_ready,
    .issue_instr, .issue_id, .issue_rs1,
    .issue_accept, .issue_writeback,
    .q (link_q.source)
  );

  fpm_op_queue u_queue (
    .ck, .rst,
    .commit_valid, .commit_id, .commit_kill,
    .q (link_q.sink),
    .x (link_x.source)
  );

  fpm_execute u_execute (
    .ck, .rst,
    .x (link_x.sink),
    .mem_valid, .mem_ready, .mem_we,
    .mem_addr, .mem_wdata, .mem_id,
    .mem_result_valid, .mem_rdata,
    .result_valid, .result_ready,
    .result_id, .result_rd, .result_data
  );

endmodule

// ==== fpm_properties.sv ====
`timescale 1ns/1ps

module fpm_properties import fpm_pkg::*; (
  input logic     ck,
  input logic     rst,
  input logic     mem_valid,
  input logic     mem_ready,
  input logic     mem_we,
  input x_word_t  mem_addr,
  input fp_word_t mem_wdata,
  input xid_t     mem_id,
  input logic     result_valid,
  input logic     result_ready,
  input xid_t     result_id,
  input reg_idx_t result_rd,
  input x_word_t  result_data,
  input logic     q_push,      // Op landing in the queue
  input logic     q_full       // Every queue slot taken
);

  // Memory request and payload hold until mem_ready
  a_mem_hold: assert property (@(posedge ck) disable iff (!rst)
    mem_valid && !mem_ready |=> mem_valid && $stable({mem_we, mem_addr, mem_wdata, mem_id}))
    else $error("memory request dropped or changed before mem_ready");

  // Same for the result channel
  a_result_hold: assert property (@(posedge ck) disable iff (!rst)
    result_valid && !result_ready |=> result_valid && $stable({result_id, result_rd, result_data}))
    else $error("result dropped or changed before result_ready");

  // Issue credits keep a push away from a full queue
  a_push_room: assert property (@(posedge ck) disable iff (!rst)
    q_push |-> !q_full)
    else $error("queue push while every slot is taken");

endmodule

bind fpm_top fpm_properties u_props (
  .ck, .rst,
  .mem_valid, .mem_ready, .mem_we, .mem_addr, .mem_wdata, .mem_id,
  .result_valid, .result_ready, .result_id, .result_rd, .result_data,
  .q_push (link_q.op_valid),
  .q_full (&u_queue.occ_q)
);

// ==== fpm_tb.sv ====
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fpm_tb import fpm_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int OP_COUNT     = 64;  // Ops over all tests, rounded up
  localparam int OP_CYCLES    = 24;  // Issue, commit, queue and slowest memory access
  localparam int MAX_CYCLES   = RESET_CYCLES + OP_COUNT * OP_CYCLES;

  logic     ck;
  logic     rst;
  logic     issue_valid, issue_ready, issue_accept, issue_writeback;
  instr_t   issue_instr;
  xid_t     issue_id;
  x_word_t  issue_rs1;
  logic     commit_valid, commit_kill;
  xid_t     commit_id;
  logic     mem_valid, mem_we;
  logic     mem_ready = 1'b0;         // Driven by the memory model
  logic     mem_result_valid = 1'b0;
  fp_word_t mem_rdata = '0;
  x_word_t  mem_addr;
  fp_word_t mem_wdata;
  xid_t     mem_id;
  logic     result_valid;
  logic     result_ready = 1'b1;      // Driven by the result monitor
  xid_t     result_id;
  reg_idx_t result_rd;
  x_word_t  result_data;

  fp_word_t fregs [32];     // Shadow FP registers
  fp_word_t mem_arr [16];   // Word memory, 64 bytes
  xid_t     next_id = '0;
  integer   seed = 83283;
  int       errors = 0;
  int       checks = 0;
  int       cycle_count = 0;
  int       load_wait = 0;  // Cycles to the load answer
  x_word_t  load_addr;
  logic     res_hold = 1'b0;

  // Observed traffic, in arrival order
  xid_t     res_id [$];
  reg_idx_t res_rd [$];
  x_word_t  res_data [$];
  xid_t     req_id [$];
  x_word_t  req_addr [$];
  logic     req_we [$];
  fp_word_t req_wdata [$];

  fpm_top DUT (
    .ck, .rst,
    .issue_valid, .issue_ready, .issue_instr, .issue_id, .issue_rs1,
    .issue_accept, .issue_writeback,
    .commit_valid, .commit_id, .commit_kill,
    .mem_valid, .mem_ready, .mem_we, .mem_addr, .mem_wdata, .mem_id,
    .mem_result_valid, .mem_rdata,
    .result_valid, .result_ready, .result_id, .result_rd, .result_data
  );

  initial begin
    ck = 1'b0;
    forever #50 ck = ~ck;
  end

  // ---------------------------------------------------------------------------
  // Memory and result models
  // ---------------------------------------------------------------------------

  function automatic fp_word_t pattern_at(x_word_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;  // Every address bit counts
  endfunction

  always @(negedge ck) begin
    mem_ready        = 1'b0;
    mem_result_valid = 1'b0;
    if (rst) begin
      if (load_wait > 0) begin  // Load in flight
        load_wait = load_wait - 1;
        if (load_wait == 0) begin
          mem_result_valid = 1'b1;
          mem_rdata        = mem_arr[load_addr[5:2]];
        end
      end else if (mem_valid && (($random(seed) & 3) != 0)) begin
        mem_ready = 1'b1;  // Handshake on the coming edge
        req_id.push_back(mem_id);
        req_addr.push_back(mem_addr);
        req_we.push_back(mem_we);
        req_wdata.push_back(mem_wdata);
        if (mem_we) begin
          mem_arr[mem_addr[5:2]] = mem_wdata;
        end else begin
          load_addr = mem_addr;
          load_wait = 1 + ($random(seed) & 3);  // Latency 1 to 4
        end
      end
    end
  end

  always @(negedge ck) begin
    result_ready = !res_hold;
    if (rst && result_valid && result_ready) begin
      res_id.push_back(result_id);
      res_rd.push_back(result_rd);
      res_data.push_back(result_data);
    end
  end

  // ---------------------------------------------------------------------------
  // Encoders and helpers
  // ---------------------------------------------------------------------------

  function automatic instr_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b1010011};
  endfunction

  function automatic instr_t load_word(logic [11:0] imm, reg_idx_t rs1, reg_idx_t rd);
    return {imm, rs1, 3'b010, rd, 7'b0000111};
  endfunction

  function automatic instr_t store_word(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100111};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic issue_op(input instr_t instr, input x_word_t rs1v, input logic exp_acc,
                          input logic exp_wb, output xid_t id);
    id = next_id;
    while (!issue_ready) @(negedge ck);  // Wait for a credit
    issue_valid = 1'b1;
    issue_instr = instr;
    issue_id    = id;
    issue_rs1   = rs1v;
    @(negedge ck);
    compare("issue_accept", 32'(issue_accept), 32'(exp_acc));
    compare("issue_writeback", 32'(issue_writeback), 32'(exp_wb));
    issue_valid = 1'b0;
    if (exp_acc) next_id = next_id + 1'b1;
  endtask

  task automatic commit_op(input xid_t id, input logic kill);
    commit_valid = 1'b1;
    commit_id    = id;
    commit_kill  = kill;
    @(negedge ck);
    commit_valid = 1'b0;
    commit_kill  = 1'b0;
  endtask

  task automatic run_op(input instr_t instr, input x_word_t rs1v, input logic wb,
                        input logic kill, output xid_t id);
    issue_op(instr, rs1v, 1'b1, wb, id);
    commit_op(id, kill);
  endtask

  task automatic take_result(input xid_t exp_id, input reg_idx_t exp_rd, input x_word_t exp);
    while (res_id.size() == 0) @(negedge ck);
    compare("result_id", 32'(res_id.pop_front()), 32'(exp_id));
    compare("result_rd", 32'(res_rd.pop_front()), 32'(exp_rd));
    compare("result_data", res_data.pop_front(), exp);
  endtask

  task automatic take_mem_req(input xid_t exp_id, input x_word_t exp_addr, input logic exp_we,
                              input fp_word_t exp);
    while (req_addr.size() == 0) @(negedge ck);
    compare("mem_id", 32'(req_id.pop_front()), 32'(exp_id));
    compare("mem_addr", req_addr.pop_front(), exp_addr);
    compare("mem_we", 32'(req_we.pop_front()), 32'(exp_we));
    if (exp_we) compare("mem_wdata", req_wdata.pop_front(), exp);
    else void'(req_wdata.pop_front());
  endtask

  task automatic write_reg(input reg_idx_t f, input fp_word_t value);
    xid_t id;
    run_op(r_type(7'b1111000, 5'd0, 5'd11, 3'b000, f), value, 1'b0, 1'b0, id);  // FMV.W.X
    fregs[f] = value;
  endtask

  task automatic read_back(input reg_idx_t f, input fp_word_t exp);
    xid_t id;
    run_op(r_type(7'b1110000, 5'd0, f, 3'b000, 5'd7), '0, 1'b1, 1'b0, id);  // FMV.X.W
    take_result(id, 5'd7, exp);
  endtask

  task automatic expect_quiet(input string what);
    repeat (4) @(negedge ck);
    checks++;
    if (res_id.size() != 0 || req_addr.size() != 0) begin
      errors++;
      $display("unexpected result or memory request after %s", what);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Directed tests
  // ---------------------------------------------------------------------------

  task automatic move_round_trip();
    xid_t id;
    read_back(5'd20, '0);  // Registers clear after reset
    write_reg(5'd3, 32'hdead_beef);
    write_reg(5'd4, 32'h0000_1234);
    run_op(r_type(7'b1110000, 5'd0, 5'd3, 3'b000, 5'd11), '0, 1'b1, 1'b0, id);
    take_result(id, 5'd11, 32'hdead_beef);  // Own id and rd come back
    read_back(5'd4, 32'h0000_1234);
  endtask

  task automatic sign_injection();
    reg_idx_t a_src [2];
    reg_idx_t b_src [2];
    reg_idx_t rd;
    logic     s;
    xid_t     id;
    a_src = '{5'd1, 5'd5};
    b_src = '{5'd2, 5'd6};
    write_reg(5'd1, 32'h3fc0_0000);  // +1.5
    write_reg(5'd5, 32'hc049_0fdb);  // -pi
    write_reg(5'd2, 32'hbf80_0000);  // -1.0
    write_reg(5'd6, 32'h4000_0000);  // +2.0
    for (int a = 0; a < 2; a++) begin
      for (int b = 0; b < 2; b++) begin
        for (int r = 0; r < 3; r++) begin
          rd = reg_idx_t'(16 + r);
          case (r)
            0:       s = fregs[b_src[b]][31];
            1:       s = ~fregs[b_src[b]][31];
            default: s = fregs[a_src[a]][31] ^ fregs[b_src[b]][31];
          endcase
          run_op(r_type(7'b0010000, b_src[b], a_src[a], 3'(r), rd), '0, 1'b0, 1'b0, id);
          fregs[rd] = {s, fregs[a_src[a]][30:0]};  // Magnitude of rs1
          read_back(rd, fregs[rd]);
        end
      end
    end
  endtask

  task automatic load_store();
    xid_t id;
    run_op(load_word(12'h008, 5'd9, 5'd12), 32'h10, 1'b0, 1'b0, id);
    take_mem_req(id, 32'h18, 1'b0, '0);
    fregs[12] = pattern_at(32'h18);
    read_back(5'd12, fregs[12]);
    run_op(store_word(12'h014, 5'd3, 5'd9), 32'h20, 1'b0, 1'b0, id);
    take_mem_req(id, 32'h34, 1'b1, fregs[3]);
    run_op(load_word(12'hff4, 5'd9, 5'd13), 32'h40, 1'b0, 1'b0, id);  // Negative offset
    take_mem_req(id, 32'h34, 1'b0, '0);
    fregs[13] = fregs[3];
    read_back(5'd13, fregs[13]);
  endtask

  task automatic kill_skip();
    xid_t ia, ik, is, ir;
    issue_op(r_type(7'b1111000, 5'd0, 5'd11, 3'b000, 5'd14), 32'h1111, 1'b1, 1'b0, ia);
    issue_op(r_type(7'b1111000, 5'd0, 5'd11, 3'b000, 5'd14), 32'h2222, 1'b1, 1'b0, ik);
    issue_op(store_word(12'h000, 5'd3, 5'd9), 32'h3c, 1'b1, 1'b0, is);
    issue_op(r_type(7'b1110000, 5'd0, 5'd14, 3'b000, 5'd8), '0, 1'b1, 1'b1, ir);
    commit_op(ir, 1'b0);  // Decisions arrive out of order
    commit_op(is, 1'b1);
    commit_op(ik, 1'b1);
    commit_op(ia, 1'b0);
    fregs[14] = 32'h1111;
    take_result(ir, 5'd8, 32'h1111);
    expect_quiet("killed instructions");
    write_reg(5'd15, 32'h3333);
    read_back(5'd14, fregs[14]);
    read_back(5'd15, fregs[15]);
  endtask

  task automatic result_stall();
    reg_idx_t src [`FPM_QUEUE_DEPTH + 1];
    xid_t     ids [`FPM_QUEUE_DEPTH + 1];
    int       waited;
    src = '{5'd3, 5'd4, 5'd12, 5'd15, 5'd14};
    @(posedge ck);
    res_hold = 1'b1;
    @(negedge ck);
    // One op parks in execute, the rest fill the queue
    for (int i = 0; i < `FPM_QUEUE_DEPTH + 1; i++) begin
      issue_op(r_type(7'b1110000, 5'd0, src[i], 3'b000, reg_idx_t'(20 + i)), '0,
               1'b1, 1'b1, ids[i]);
      commit_op(ids[i], 1'b0);
    end
    waited = 0;
    while (issue_ready && waited < 4) begin
      @(negedge ck);
      waited++;
    end
    checks++;
    if (issue_ready) begin
      errors++;
      $display("issue_ready stayed high with %0d instructions pending", `FPM_QUEUE_DEPTH);
    end
    compare("result_valid", 32'(result_valid), 32'd1);  // First move waits in execute
    @(posedge ck);
    res_hold = 1'b0;
    @(negedge ck);
    for (int i = 0; i < `FPM_QUEUE_DEPTH + 1; i++) begin
      take_result(ids[i], reg_idx_t'(20 + i), fregs[src[i]]);  // Issue order
    end
  endtask

  task automatic illegal_word();
    xid_t id;
    issue_op(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3), '0, 1'b0, 1'b0, id);  // FADD.S
    issue_op(r_type(7'b0010000, 5'd2, 5'd1, 3'b011, 5'd3), '0, 1'b0, 1'b0, id);  // Bad rm
    issue_op(r_type(7'b1110000, 5'd4, 5'd1, 3'b000, 5'd3), '0, 1'b0, 1'b0, id);  // rs2 set
    issue_op({12'h000, 5'd9, 3'b011, 5'd3, 7'b0000111}, '0, 1'b0, 1'b0, id);     // FLD
    expect_quiet("unsupported words");
    read_back(5'd3, fregs[3]);
  endtask

  // ---------------------------------------------------------------------------
  // Run control
  // ---------------------------------------------------------------------------

  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge ck);
      cycle_count++;
    end
    $display("timeout after %0d cycles, a handshake never completed", MAX_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst          = 1'b0;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_id     = '0;
    issue_rs1    = '0;
    commit_valid = 1'b0;
    commit_id    = '0;
    commit_kill  = 1'b0;
    for (int i = 0; i < 32; i++) fregs[i] = '0;
    for (int i = 0; i < 16; i++) mem_arr[i] = pattern_at(x_word_t'(i * 4));
    repeat (RESET_CYCLES) @(negedge ck);
    rst = 1'b1;
    @(negedge ck);
    compare("issue_ready", 32'(issue_ready), 32'd1);
    compare("mem_valid", 32'(mem_valid), 32'd0);
    compare("result_valid", 32'(result_valid), 32'd0);
    move_round_trip();
    sign_injection();
    load_store();
    kill_skip();
    result_stall();
    illegal_word();
    expect_quiet("the last test");
    $display("checks: %0d  errors: %0d  cycles: %0d", checks, errors, cycle_count);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
fpm_pkg.sv
fpm_op_if.sv
fpm_issue.sv
fpm_op_queue.sv
fpm_execute.sv
fpm_top.sv
fpm_properties.sv
fpm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the FP coprocessor testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module fpm_tb -o fpm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fpm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
